// ==== filelist.f ====
logic/ig_pkg.sv
logic/pixel_fetch.sv
logic/row_window.sv
logic/grad_unit.sv
logic/ig_top.sv
sim/ig_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the gradient engine testbench with Verilator
# the exit status follows the simulation result

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module ig_tb \
    -Mdir obj_dir \
    -f filelist.f &&
./obj_dir/Vig_tb ||
{ echo "simulation failed"; exit 1; }

echo "simulation finished"

// ==== sim/ig_tb.sv ====
`timescale 1ns/100ps

module ig_tb;
    import ig_pkg::*;

    localparam int          NUM_PIX         = IMG_W * IMG_H;
    localparam int          LAST_INTERIOR   = (IMG_H - 2) * IMG_W + (IMG_W - 2);
    localparam int          INTERIOR_WRITES = (IMG_W - 1) * (IMG_H - 1);
    localparam grad_t       SENTINEL        = 20'h80200;
    localparam logic [31:0] SEED            = 32'h9556cf2f;
    localparam int          WATCHDOG_CYCLES = 2 * (NUM_PIX + 600);

    logic   clk = 1'b0;
    logic   reset;
    logic   img_rd;
    addr_t  img_addr;
    pixel_t img_di;
    logic   grad_wr;
    addr_t  grad_addr;
    grad_t  grad_do;
    logic   done;

    // memory models
    pixel_t image    [NUM_PIX];
    grad_t  grad_mem [NUM_PIX];
    int     wr_count [NUM_PIX];

    logic [31:0] lfsr;

    // monitor state cleared while the DUT sees reset
    logic  rst_sampled = 1'b1;
    logic  rd_pending  = 1'b0;
    addr_t pend_addr;
    int    exp_rd_addr;
    logic  rd_finished;
    logic  any_write;
    int    last_wr_addr;
    logic  last_seen;
    logic  last_prev;
    logic  done_seen;
    int    total_writes;

    ig_top DUT (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        rst_sampled <= reset;
    end

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic report_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h",
                 $time, name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    // ----------------------------------------
    // stimulus and reference model
    // ----------------------------------------

    // galois LFSR stepped once per bit taken
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return b;
    endfunction

    // mode 1 keeps every fourth row flat
    task automatic fill_image(input int mode);
        pixel_t row_val;
        row_val = '0;
        for (int a = 0; a < NUM_PIX; a++) begin
            if (mode == 1 && (a / IMG_W) % 4 == 0) begin
                if (a % IMG_W == 0) begin
                    row_val = rand_byte();
                end
                image[a] = row_val;
            end else begin
                image[a] = rand_byte();
            end
        end
    endtask

    task automatic clear_grad_mem();
        for (int a = 0; a < NUM_PIX; a++) begin
            grad_mem[a] = SENTINEL;
            wr_count[a] = 0;
        end
    endtask

    // right minus pixel in the upper half and lower minus pixel in the lower half
    function automatic grad_t model_grad(input int a);
        int gx;
        int gy;
        gx = int'(image[a + 1]) - int'(image[a]);
        gy = int'(image[a + IMG_W]) - int'(image[a]);
        return {gx[9:0], gy[9:0]};
    endfunction

    // ----------------------------------------
    // memory ports and per cycle checks
    // ----------------------------------------
    always @(negedge clk) begin
        grad_t exp_grad;
        // data for the read issued in the previous cycle
        img_di = rd_pending ? image[pend_addr] : '0;
        rd_pending = (img_rd == 1'b1);
        pend_addr = img_addr;

        if (rst_sampled) begin
            assert (img_rd == 1'b0) else report_mismatch("img_rd", 0, img_rd);
            assert (grad_wr == 1'b0) else report_mismatch("grad_wr", 0, grad_wr);
            assert (done == 1'b0) else report_mismatch("done", 0, done);
            exp_rd_addr  = 0;
            rd_finished  = 1'b0;
            any_write    = 1'b0;
            last_wr_addr = 0;
            last_seen    = 1'b0;
            last_prev    = 1'b0;
            done_seen    = 1'b0;
            total_writes = 0;
        end else begin
            // one image read per cycle in raster order
            if (!rd_finished) begin
                assert (img_rd == 1'b1) else report_mismatch("img_rd", 1, img_rd);
                assert (img_addr == addr_t'(exp_rd_addr))
                    else report_mismatch("img_addr", exp_rd_addr, img_addr);
                exp_rd_addr++;
                rd_finished = (exp_rd_addr == NUM_PIX);
            end else begin
                assert (img_rd == 1'b0) else report_mismatch("img_rd", 0, img_rd);
            end

            if (done) begin
                assert (last_seen) else report_error("done rose before the last interior write");
                assert (!grad_wr) else report_mismatch("grad_wr", 0, grad_wr);
                done_seen = 1'b1;
            end else begin
                assert (!done_seen) else report_error("done fell without a reset");
                assert (!last_prev) else report_error("done late after the last interior write");
            end

            last_prev = 1'b0;
            if (grad_wr) begin
                assert (grad_addr[15:8] != LAST_COORD && grad_addr[7:0] != LAST_COORD)
                    else report_error("write to an address in the last row or column");
                assert (!any_write || int'(grad_addr) > last_wr_addr)
                    else report_error("write addresses not strictly ascending");
                exp_grad = model_grad(int'(grad_addr));
                assert (grad_do == exp_grad) else report_mismatch("grad_do", exp_grad, grad_do);
                grad_mem[grad_addr] = grad_do;
                wr_count[grad_addr]++;
                total_writes++;
                any_write    = 1'b1;
                last_wr_addr = int'(grad_addr);
                if (int'(grad_addr) == LAST_INTERIOR) begin
                    last_seen = 1'b1;
                    last_prev = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // end of frame checks
    // ----------------------------------------
    task automatic check_frame();
        for (int a = 0; a < NUM_PIX; a++) begin
            if (a / IMG_W == IMG_H - 1 || a % IMG_W == IMG_W - 1) begin
                assert (grad_mem[a] == SENTINEL)
                    else report_mismatch("grad_mem border", SENTINEL, grad_mem[a]);
            end else begin
                assert (wr_count[a] == 1) else report_mismatch("write count", 1, wr_count[a]);
                assert (grad_mem[a] == model_grad(a))
                    else report_mismatch("grad_mem", model_grad(a), grad_mem[a]);
            end
        end
        assert (total_writes == INTERIOR_WRITES)
            else report_mismatch("total writes", INTERIOR_WRITES, total_writes);
    endtask

    task automatic run_frame(input int mode);
        reset = 1'b1;
        fill_image(mode);
        clear_grad_mem();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (done !== 1'b1) @(negedge clk);
        // a few idle cycles to see that nothing more happens
        repeat (20) @(negedge clk);
        check_frame();
    endtask

    initial begin
        reset  = 1'b1;
        img_di = '0;
        lfsr   = SEED;
        run_frame(0);
        run_frame(1);
        $display("STATUS: PASS");
        $finish;
    end

    // two frames plus some slack
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_error("watchdog timeout, the run did not complete");
    end

endmodule

// ==== logic/ig_top.sv ====
`timescale 1ns/100ps

module ig_top (
    input  logic           clk,
    input  logic           reset,
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_di,
    output logic           grad_wr,
    output ig_pkg::addr_t  grad_addr,
    output ig_pkg::grad_t  grad_do,
    output logic           done
);
    import ig_pkg::*;

    // stage to stage beats
    pixel_beat_t beat;
    window_t     win;

    // ----------------------------------------
    // image read and position tagging
    // ----------------------------------------
    pixel_fetch u_fetch (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .beat     (beat)
    );

    // ----------------------------------------
    // neighbor assembly
    // ----------------------------------------
    row_window u_window (
        .clk   (clk),
        .reset (reset),
        .beat  (beat),
        .win   (win)
    );

    // ----------------------------------------
    // gradient and write back
    // ----------------------------------------
    grad_unit u_grad (
        .clk       (clk),
        .reset     (reset),
        .win       (win),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

// ==== logic/grad_unit.sv ====
`timescale 1ns/100ps

module grad_unit (
    input  logic            clk,
    input  logic            reset,
    input  ig_pkg::window_t win,
    output logic            grad_wr,
    output ig_pkg::addr_t   grad_addr,
    output ig_pkg::grad_t   grad_do,
    output logic            done
);
    import ig_pkg::*;

    grad_comp_t gx;
    grad_comp_t gy;
    logic       last_write;

    // ----------------------------------------
    // forward differences
    // ----------------------------------------

    // pixels are unsigned, so the casts zero extend before the subtract
    assign gx = grad_comp_t'(win.right) - grad_comp_t'(win.center);
    assign gy = grad_comp_t'(win.below) - grad_comp_t'(win.center);

    // ----------------------------------------
    // gradient memory write
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else begin
            grad_wr <= win.valid;
        end
    end

    always_ff @(posedge clk) begin
        grad_addr <= {win.row, win.col};
        grad_do   <= {gx, gy};
    end

    // ----------------------------------------
    // completion
    // ----------------------------------------

    // last interior position, one row and column in from the far corner
    assign last_write = grad_wr &&
        (grad_addr == {coord_t'(LAST_COORD - 1), coord_t'(LAST_COORD - 1)});

    // sticky until the next reset
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (last_write) begin
            done <= 1'b1;
        end
    end

endmodule

// ==== logic/row_window.sv ====
`timescale 1ns/100ps

module row_window (
    input  logic                clk,
    input  logic                reset,
    input  ig_pkg::pixel_beat_t beat,
    output ig_pkg::window_t     win
);
    import ig_pkg::*;

    // previous row, indexed by column
    pixel_t line_mem [IMG_W];

    // pixel above the current beat
    pixel_t upper;

    // upper and current pixels of the previous column
    pixel_t prev_upper;
    pixel_t prev_cur;

    // window exists only once a full 2x2 block is available
    logic   win_ok;

    // ----------------------------------------
    // line buffer
    // ----------------------------------------

    // read before write, the entry still holds the row above
    assign upper = line_mem[beat.col];

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            line_mem[beat.col] <= beat.pixel;
        end
    end

    // ----------------------------------------
    // previous column registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            prev_upper <= upper;
            prev_cur   <= beat.pixel;
        end
    end

    // ----------------------------------------
    // window output
    // ----------------------------------------

    // row 0 has nothing above, col 0 has no left column yet
    assign win_ok = beat.valid && (beat.row != '0) && (beat.col != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            win.valid <= 1'b0;
        end else begin
            win.valid <= win_ok;
        end
    end

    // window is for the pixel up and to the left of the beat
    always_ff @(posedge clk) begin
        win.row    <= beat.row - 1'b1;
        win.col    <= beat.col - 1'b1;
        win.center <= prev_upper;
        win.right  <= upper;
        win.below  <= prev_cur;
    end

endmodule

// ==== logic/pixel_fetch.sv ====
`timescale 1ns/100ps

module pixel_fetch (
    input  logic                clk,
    input  logic                reset,
    output logic                img_rd,
    output ig_pkg::addr_t       img_addr,
    input  ig_pkg::pixel_t      img_di,
    output ig_pkg::pixel_beat_t beat
);
    import ig_pkg::*;

    // high until the last address has been issued
    logic  running;
    logic  last_addr;

    // address and strobe of the previous cycle, lined up with img_di
    logic  rd_q;
    addr_t addr_q;

    assign last_addr = (img_addr == {LAST_COORD, LAST_COORD});

    // ----------------------------------------
    // raster address counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            running  <= 1'b1;
            img_rd   <= 1'b0;
            img_addr <= '0;
        end else begin
            // one read per cycle, stop after the last pixel
            img_rd <= running && !(img_rd && last_addr);
            if (img_rd) begin
                img_addr <= img_addr + 1'b1;
            end
            if (img_rd && last_addr) begin
                running <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // read return tagging
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= img_rd;
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= img_addr;
    end

    // memory data arrives one cycle after the address
    always_comb begin
        beat.valid             = rd_q;
        {beat.row, beat.col}   = addr_q;
        beat.pixel             = img_di;
    end

endmodule

// ==== logic/ig_pkg.sv ====
package ig_pkg;

    // ----------------------------------------
    // image geometry
    // ----------------------------------------
    localparam int IMG_W = 256;
    localparam int IMG_H = 256;

    // ----------------------------------------
    // vector types
    // ----------------------------------------
    typedef logic [7:0] pixel_t;

    // row or column index, sized from the image width
    typedef logic [$clog2(IMG_W)-1:0] coord_t;

    // raster address, row in the upper half and column in the lower half
    typedef logic [$clog2(IMG_W*IMG_H)-1:0] addr_t;

    localparam coord_t LAST_COORD = coord_t'(IMG_W - 1);

    // one signed difference of two pixels
    typedef logic signed [9:0] grad_comp_t;

    // horizontal component high, vertical component low
    typedef logic [19:0] grad_t;

    // ----------------------------------------
    // stage structs
    // ----------------------------------------

    // pixel returned by the image memory, tagged with its position
    typedef struct packed {
        logic   valid;
        coord_t row;
        coord_t col;
        pixel_t pixel;
    } pixel_beat_t;

    // the three pixels for the gradient at (row, col)
    typedef struct packed {
        logic   valid;
        coord_t row;
        coord_t col;
        pixel_t center;
        pixel_t right;
        pixel_t below;
    } window_t;

endpackage
